//--- src/iq_cfg_pkg.sv
`default_nettype none

package iq_cfg_pkg;

	// queue geometry
	localparam int NUM_SLOTS = 32;	// slot 0 is the oldest entry.
	localparam int FILL_W    = 4;	// new instructions per advance, also the shift distance.
	localparam int NUM_WAKE  = 4;	// writeback lanes broadcast each cycle.

	// entry fields
	localparam int REG_W = 5;	// architectural register number.
	localparam int TAG_W = 5;	// instruction tag.
	localparam int BRM_W = 3;	// one bit per unresolved branch.
	localparam int OPC_W = 7;

	// status is valid, source-1 ready and source-2 ready.
	localparam int STAT_W = 3;

	// issued word drops the status bits.
	localparam int ISSUE_W = OPC_W + BRM_W + TAG_W + 3 * REG_W;
	localparam int ENTRY_W = ISSUE_W + STAT_W;

endpackage

`default_nettype wire

//--- src/iq_types_pkg.sv
`default_nettype none

package iq_types_pkg;

	import iq_cfg_pkg::*;

	// payload that leaves the queue on issue.
	typedef struct packed {
		logic [OPC_W-1:0] opcode;
		logic [BRM_W-1:0] brmask;	// branches this instruction depends on.
		logic [TAG_W-1:0] tag;
		logic [REG_W-1:0] dest;
		logic [REG_W-1:0] src1;
		logic [REG_W-1:0] src2;
	} iq_issue_t;

	// full slot contents, status bits in the low three positions.
	typedef struct packed {
		iq_issue_t issue;
		logic      valid;
		logic      src1_rdy;	// source 1 value is available.
		logic      src2_rdy;	// source 2 value is available.
	} iq_entry_t;

endpackage

`default_nettype wire

//--- src/iq_bcast_if.sv
`default_nettype none

interface iq_bcast_if;

	import iq_cfg_pkg::*;

	logic [NUM_WAKE-1:0]            wake_valid;	// one strobe per writeback lane.
	logic [NUM_WAKE-1:0][REG_W-1:0] wake_dest;	// register written on each lane.
	logic [BRM_W-1:0]               kill_mask;	// mispredicted branches this cycle.
	logic                           advance;	// shift the queue down by FILL_W.

	modport source (
		output wake_valid,
		output wake_dest,
		output kill_mask,
		output advance
	);

	modport slot (
		input wake_valid,
		input wake_dest,
		input kill_mask,
		input advance
	);

endinterface

`default_nettype wire

//--- src/iq_slot.sv
`default_nettype none

module iq_slot (
	input  wire logic                    i_clk,
	input  wire logic                    i_rst_n,
	iq_bcast_if.slot                     bcast,
	input  wire iq_types_pkg::iq_entry_t i_shift_in,
	input  wire logic                    i_grant,
	output iq_types_pkg::iq_entry_t      o_entry,
	output iq_types_pkg::iq_entry_t      o_next,
	output logic                         o_request
);

	import iq_cfg_pkg::*;
	import iq_types_pkg::*;

	iq_issue_t issue_q;	// payload, only meaningful while valid_q is set.
	logic      valid_q;
	logic      rdy1_q;
	logic      rdy2_q;

	iq_entry_t cur;
	iq_entry_t upd;
	iq_entry_t load;
	logic      wake1;
	logic      wake2;
	logic      killed;

	assign cur.issue    = issue_q;
	assign cur.valid    = valid_q;
	assign cur.src1_rdy = rdy1_q;
	assign cur.src2_rdy = rdy2_q;

	// any lane whose destination matches a source wakes that source.
	always_comb begin
		wake1 = 1'b0;
		wake2 = 1'b0;
		for (int l = 0; l < NUM_WAKE; l++) begin
			if (bcast.wake_valid[l] && bcast.wake_dest[l] == issue_q.src1) begin
				wake1 = 1'b1;
			end
			if (bcast.wake_valid[l] && bcast.wake_dest[l] == issue_q.src2) begin
				wake2 = 1'b1;
			end
		end
	end

	assign killed = |(issue_q.brmask & bcast.kill_mask);	// on a squashed path.

	// update order is wakeup, then kill, then the issue clear.
	always_comb begin
		upd = cur;
		if (wake1) begin
			upd.src1_rdy = 1'b1;
		end
		if (wake2) begin
			upd.src2_rdy = 1'b1;
		end
		if (killed) begin
			upd.valid = 1'b0;
		end
		if (i_grant) begin
			upd.valid = 1'b0;	// issued entries leave at the next edge.
		end
	end

	// on advance take the entry from FILL_W slots above, otherwise keep our own.
	assign load = bcast.advance ? i_shift_in : upd;

	always_ff @(posedge i_clk) begin
		issue_q <= load.issue;
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			valid_q <= 1'b0;
			rdy1_q  <= 1'b0;
			rdy2_q  <= 1'b0;
		end else begin
			valid_q <= load.valid;
			rdy1_q  <= load.src1_rdy;
			rdy2_q  <= load.src2_rdy;
		end
	end

	assign o_entry   = cur;
	assign o_next    = upd;
	assign o_request = valid_q & rdy1_q & rdy2_q;	// ready to execute.

endmodule

`default_nettype wire

//--- src/iq_select.sv
`default_nettype none

module iq_select (
	input  wire logic [iq_cfg_pkg::NUM_SLOTS-1:0] i_request,
	input  wire iq_types_pkg::iq_entry_t          i_entries [iq_cfg_pkg::NUM_SLOTS],
	output logic [iq_cfg_pkg::NUM_SLOTS-1:0]      o_grant,
	output iq_types_pkg::iq_issue_t               o_issue,
	output logic                                  o_ready
);

	import iq_cfg_pkg::*;
	import iq_types_pkg::*;

	// scan from the top so the lowest request, the oldest, is the one that remains.
	always_comb begin
		o_grant = '0;
		for (int s = NUM_SLOTS - 1; s >= 0; s--) begin
			if (i_request[s]) begin
				o_grant    = '0;
				o_grant[s] = 1'b1;
			end
		end
	end

	// grant is one-hot or zero, so an OR of masked words is the mux.
	always_comb begin
		o_issue = '0;
		for (int s = 0; s < NUM_SLOTS; s++) begin
			if (o_grant[s]) begin
				o_issue = o_issue | i_entries[s].issue;
			end
		end
	end

	assign o_ready = |i_request;

endmodule

`default_nettype wire

//--- src/iq_queue4in1.sv
`default_nettype none

module iq_queue4in1 (
	input  wire logic                                            i_clk,
	input  wire logic                                            i_rst_n,
	input  wire logic                                            i_en,
	input  wire logic [iq_cfg_pkg::ENTRY_W-1:0]                  i_inst1,
	input  wire logic [iq_cfg_pkg::ENTRY_W-1:0]                  i_inst2,
	input  wire logic [iq_cfg_pkg::ENTRY_W-1:0]                  i_inst3,
	input  wire logic [iq_cfg_pkg::ENTRY_W-1:0]                  i_inst4,
	input  wire logic [iq_cfg_pkg::NUM_WAKE-1:0]                 i_wake_valid,
	input  wire logic [iq_cfg_pkg::NUM_WAKE*iq_cfg_pkg::REG_W-1:0] i_wdest4x,
	input  wire logic [iq_cfg_pkg::BRM_W-1:0]                    i_brkill,
	output logic [iq_cfg_pkg::ISSUE_W-1:0]                       o_inst1,
	output logic                                                 o_ready
);

	import iq_cfg_pkg::*;
	import iq_types_pkg::*;

	iq_bcast_if bcast ();

	// slot_next has FILL_W extra positions above the queue for the incoming instructions.
	iq_entry_t slot_next  [NUM_SLOTS + FILL_W];
	iq_entry_t slot_entry [NUM_SLOTS];

	logic [NUM_SLOTS-1:0] request;
	logic [NUM_SLOTS-1:0] grant;
	iq_issue_t            issue_word;

	// lane 0 sits in the low bits of i_wdest4x.
	assign bcast.wake_valid = i_wake_valid;
	assign bcast.wake_dest  = i_wdest4x;
	assign bcast.kill_mask  = i_brkill;
	assign bcast.advance    = i_en;

	// new instructions enter as given, no wakeup or kill on the way in.
	assign slot_next[NUM_SLOTS]     = iq_entry_t'(i_inst1);
	assign slot_next[NUM_SLOTS + 1] = iq_entry_t'(i_inst2);
	assign slot_next[NUM_SLOTS + 2] = iq_entry_t'(i_inst3);
	assign slot_next[NUM_SLOTS + 3] = iq_entry_t'(i_inst4);

	for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
		iq_slot u_slot (
			.i_clk      (i_clk),
			.i_rst_n    (i_rst_n),
			.bcast      (bcast),
			.i_shift_in (slot_next[i + FILL_W]),
			.i_grant    (grant[i]),
			.o_entry    (slot_entry[i]),
			.o_next     (slot_next[i]),
			.o_request  (request[i])
		);
	end

	iq_select u_select (
		.i_request (request),
		.i_entries (slot_entry),
		.o_grant   (grant),
		.o_issue   (issue_word),
		.o_ready   (o_ready)
	);

	assign o_inst1 = issue_word;	// zero when nothing is ready.

endmodule

`default_nettype wire

//--- test/iq_chk.sv
`default_nettype none

module iq_chk (
	input wire logic                             i_clk,
	input wire logic                             i_rst_n,
	input wire logic [iq_cfg_pkg::NUM_SLOTS-1:0] i_grant,
	input wire logic                             i_ready,
	input wire iq_types_pkg::iq_entry_t          i_entries [iq_cfg_pkg::NUM_SLOTS]
);

	import iq_cfg_pkg::*;
	import iq_types_pkg::*;

	logic [NUM_SLOTS-1:0] valid_bits;

	always_comb begin
		for (int s = 0; s < NUM_SLOTS; s++) begin
			valid_bits[s] = i_entries[s].valid;
		end
	end

	grant_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$onehot0(i_grant))
		else $error("more than one slot granted in one cycle");

	// a request always produces a grant, so ready and grant go together.
	ready_matches_grant: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_ready == (i_grant != '0))
		else $error("o_ready disagrees with the grant vector");

	empty_after_reset: assert property (@(posedge i_clk)
		!i_rst_n |=> valid_bits == '0)
		else $error("valid slots remain after reset");	// reset is synchronous.

endmodule

bind iq_queue4in1 iq_chk u_chk (
	.i_clk     (i_clk),
	.i_rst_n   (i_rst_n),
	.i_grant   (grant),
	.i_ready   (o_ready),
	.i_entries (slot_entry)
);

`default_nettype wire

//--- test/tb_iq.sv
`default_nettype none

module tb_iq;

	import iq_cfg_pkg::*;
	import iq_types_pkg::*;

	localparam int RAND_CYCLES = 500;
	localparam int STIM_CYCLES = 600;	// reset, directed tests and random traffic.
	localparam int MAX_CYCLES  = 2 * STIM_CYCLES;

	typedef struct packed {
		logic      ready;
		iq_issue_t issue;
	} expect_t;

	logic                           clk = 1'b0;
	logic                           rst_n;
	logic                           en;
	iq_entry_t                      new_inst [FILL_W];
	logic [NUM_WAKE-1:0]            wake_valid;
	logic [NUM_WAKE-1:0][REG_W-1:0] wake_dest;
	logic [BRM_W-1:0]               brkill;
	logic [ISSUE_W-1:0]             o_inst1;
	logic                           o_ready;
	iq_issue_t                      issued;

	iq_entry_t model [NUM_SLOTS];	// expected queue contents with slot 0 as the oldest.
	expect_t   exp_out;
	integer    seed = 32'h44f7c3b3;
	int        cycle_count = 0;
	int        num_checks = 0;

	always #5 clk = ~clk;

	iq_queue4in1 uut (
		.i_clk        (clk),
		.i_rst_n      (rst_n),
		.i_en         (en),
		.i_inst1      (new_inst[0]),
		.i_inst2      (new_inst[1]),
		.i_inst3      (new_inst[2]),
		.i_inst4      (new_inst[3]),
		.i_wake_valid (wake_valid),
		.i_wdest4x    (wake_dest),
		.i_brkill     (brkill),
		.o_inst1      (o_inst1),
		.o_ready      (o_ready)
	);

	assign issued = o_inst1;

	task automatic check_val(input string name, input logic [ISSUE_W-1:0] got,
			input logic [ISSUE_W-1:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "mismatch on %s", name);
		end else begin
			num_checks++;
		end
	endtask

	// expected outputs for the current contents, then the model moves one edge ahead.
	function automatic expect_t ref_step(
		input logic                           adv,
		input logic [NUM_WAKE-1:0]            wv,
		input logic [NUM_WAKE-1:0][REG_W-1:0] wd,
		input logic [BRM_W-1:0]               kill,
		input iq_entry_t                      ins [FILL_W]
	);
		iq_entry_t nxt [NUM_SLOTS + FILL_W];
		expect_t   res;
		int        gnt;
		res = '0;
		gnt = -1;
		for (int s = 0; s < NUM_SLOTS; s++) begin
			if (gnt < 0 && model[s].valid && model[s].src1_rdy && model[s].src2_rdy) begin
				gnt = s;	// lowest requester wins.
			end
		end
		if (gnt >= 0) begin
			res.ready = 1'b1;
			res.issue = model[gnt].issue;
		end
		for (int s = 0; s < NUM_SLOTS; s++) begin
			nxt[s] = model[s];
			for (int l = 0; l < NUM_WAKE; l++) begin
				if (wv[l] && wd[l] == model[s].issue.src1) begin
					nxt[s].src1_rdy = 1'b1;
				end
				if (wv[l] && wd[l] == model[s].issue.src2) begin
					nxt[s].src2_rdy = 1'b1;
				end
			end
			if ((model[s].issue.brmask & kill) != '0 || s == gnt) begin
				nxt[s].valid = 1'b0;
			end
		end
		for (int f = 0; f < FILL_W; f++) begin
			nxt[NUM_SLOTS + f] = ins[f];	// new instructions skip wakeup and kill.
		end
		for (int s = 0; s < NUM_SLOTS; s++) begin
			model[s] = adv ? nxt[s + FILL_W] : nxt[s];
		end
		return res;
	endfunction

	function automatic iq_entry_t make_entry(
		input logic [TAG_W-1:0] tag,
		input logic [BRM_W-1:0] brmask,
		input logic [REG_W-1:0] src1,
		input logic             rdy1,
		input logic [REG_W-1:0] src2,
		input logic             rdy2
	);
		iq_entry_t e;
		e.issue.opcode = 7'h13;
		e.issue.brmask = brmask;
		e.issue.tag    = tag;
		e.issue.dest   = REG_W'(tag);
		e.issue.src1   = src1;
		e.issue.src2   = src2;
		e.valid        = 1'b1;
		e.src1_rdy     = rdy1;
		e.src2_rdy     = rdy2;
		return e;
	endfunction

	function automatic iq_entry_t random_entry();
		iq_entry_t   e;
		logic [31:0] r;
		r = $random(seed);
		e.issue.opcode = OPC_W'(r);
		e.issue.brmask = BRM_W'(r >> 8);
		e.issue.tag    = TAG_W'(r >> 12);
		e.issue.dest   = REG_W'(r >> 17);
		e.issue.src1   = REG_W'(r >> 22);
		e.issue.src2   = REG_W'(r >> 27);
		r = $random(seed);
		e.valid    = r[1:0] != 2'b00;
		e.src1_rdy = r[2] || e.issue.src1 == '0;	// register 0 is never pending.
		e.src2_rdy = r[3] || e.issue.src2 == '0;
		return e;
	endfunction

	task automatic idle_inputs();
		en         = 1'b0;
		wake_valid = '0;
		wake_dest  = '0;
		brkill     = '0;
		for (int f = 0; f < FILL_W; f++) begin
			new_inst[f] = '0;
		end
	endtask

	task automatic random_inputs();
		logic [31:0] r;
		r = $random(seed);
		en         = r[1:0] == 2'b00;	// advance about one cycle in four.
		wake_valid = NUM_WAKE'(r >> 2);
		brkill     = (r[10:7] == 4'd0) ? BRM_W'(r >> 11) : '0;
		wake_dest  = (NUM_WAKE * REG_W)'($random(seed));
		for (int f = 0; f < FILL_W; f++) begin
			new_inst[f] = random_entry();
		end
	endtask

	task automatic expect_issue(input logic [TAG_W-1:0] tag);
		check_val("o_ready", ISSUE_W'(o_ready), ISSUE_W'(1));
		check_val("o_inst1.tag", ISSUE_W'(issued.tag), ISSUE_W'(tag));
	endtask

	task automatic expect_idle();
		check_val("o_ready", ISSUE_W'(o_ready), ISSUE_W'(0));
	endtask

	// compare one time unit before each rising edge, when inputs and outputs are settled.
	always begin
		@(negedge clk);
		#4;
		if (!rst_n) begin
			for (int s = 0; s < NUM_SLOTS; s++) begin
				model[s] = '0;
			end
		end else begin
			exp_out = ref_step(en, wake_valid, wake_dest, brkill, new_inst);
			check_val("o_ready", ISSUE_W'(o_ready), ISSUE_W'(exp_out.ready));
			check_val("o_inst1", o_inst1, exp_out.issue);
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("STATUS: FAIL");
			$fatal(1, "timeout");
		end
	end

	initial begin
		rst_n = 1'b0;
		idle_inputs();
		repeat (8) begin
			@(posedge clk);
		end
		@(negedge clk);
		rst_n = 1'b1;

		// four ready instructions enter together and leave oldest first.
		expect_idle();
		en = 1'b1;
		for (int f = 0; f < FILL_W; f++) begin
			new_inst[f] = make_entry(TAG_W'(1 + f), 3'b000, 5'd0, 1'b1, 5'd0, 1'b1);
		end
		for (int k = 0; k < 7; k++) begin
			@(negedge clk);
			if (k < FILL_W) begin
				expect_issue(TAG_W'(1 + k));
			end
			idle_inputs();
			en = 1'b1;
		end
		@(negedge clk);
		expect_idle();
		idle_inputs();

		// wakeup of a pending source.
		@(negedge clk);
		en          = 1'b1;
		new_inst[0] = make_entry(5'd9, 3'b000, 5'd5, 1'b0, 5'd0, 1'b1);
		@(negedge clk);
		idle_inputs();
		wake_valid   = 4'b0001;	// lane 1 matches but is not strobed.
		wake_dest[0] = 5'd6;
		wake_dest[1] = 5'd5;
		@(negedge clk);
		expect_idle();
		idle_inputs();
		wake_valid   = 4'b0100;
		wake_dest[2] = 5'd5;
		@(negedge clk);
		expect_issue(5'd9);
		idle_inputs();
		@(negedge clk);
		expect_idle();

		// branch kill removes only the overlapping masks.
		en          = 1'b1;
		new_inst[0] = make_entry(5'd16, 3'b010, 5'd7, 1'b0, 5'd0, 1'b1);
		new_inst[1] = make_entry(5'd17, 3'b001, 5'd7, 1'b0, 5'd0, 1'b1);
		new_inst[2] = make_entry(5'd18, 3'b110, 5'd7, 1'b0, 5'd0, 1'b1);
		new_inst[3] = make_entry(5'd19, 3'b100, 5'd7, 1'b0, 5'd0, 1'b1);
		@(negedge clk);
		expect_idle();
		idle_inputs();
		brkill = 3'b010;
		@(negedge clk);
		idle_inputs();
		wake_valid   = 4'b1000;
		wake_dest[3] = 5'd7;
		@(negedge clk);
		expect_issue(5'd17);
		idle_inputs();
		@(negedge clk);
		expect_issue(5'd19);
		@(negedge clk);
		expect_idle();

		// with advance low the inputs are ignored and the queue holds.
		en          = 1'b1;
		new_inst[0] = make_entry(5'd24, 3'b000, 5'd0, 1'b1, 5'd9, 1'b0);
		new_inst[1] = make_entry(5'd25, 3'b000, 5'd0, 1'b1, 5'd9, 1'b0);
		repeat (5) begin
			@(negedge clk);
			expect_idle();
			idle_inputs();
			for (int f = 0; f < FILL_W; f++) begin
				new_inst[f] = make_entry(5'd30, 3'b000, 5'd0, 1'b1, 5'd0, 1'b1);
			end
		end
		@(negedge clk);
		expect_idle();
		idle_inputs();
		wake_valid   = 4'b0001;
		wake_dest[0] = 5'd9;
		@(negedge clk);
		expect_issue(5'd24);
		idle_inputs();
		@(negedge clk);
		expect_issue(5'd25);

		// mixed random traffic against the model.
		for (int c = 0; c < RAND_CYCLES; c++) begin
			@(negedge clk);
			random_inputs();
		end
		@(negedge clk);
		idle_inputs();
		repeat (2) begin
			@(negedge clk);
		end
		$display("%0d checks done in %0d cycles", num_checks, cycle_count);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
src/iq_cfg_pkg.sv
src/iq_types_pkg.sv
src/iq_bcast_if.sv
src/iq_slot.sv
src/iq_select.sv
src/iq_queue4in1.sv
test/iq_chk.sv
test/tb_iq.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module tb_iq -f sources.f \
	&& ./obj_dir/Vtb_iq | tee /dev/stderr | grep -x 'STATUS: PASS' > /dev/null \
	&& echo "simulation run succeeded" \
	|| { echo "simulation run did not succeed"; exit 1; }
